//--- trig_pkg.sv
// shared widths, depths and record layout for the ttc trigger block, referenced as trig_pkg::name
package trig_pkg;

    // ----------------------------------------
    // trigger fields
    // ----------------------------------------
    localparam int TRIG_NUM_W  = 24;  // global trigger number
    localparam int TRIG_TYPE_W = 5;   // muon fill, laser, pedestal, ...
    localparam int TIMESTAMP_W = 44;  // free-running 40 MHz count

    localparam int N_CHAN  = 5;       // channel fpgas on the board
    localparam int DELAY_W = 8;       // trigger delay setting, in ttc_clk cycles

    // ----------------------------------------
    // event record layout
    // ----------------------------------------
    // number in the low bits, type above it, timestamp on top
    localparam int ACQ_REC_W    = TRIG_NUM_W + TRIG_TYPE_W + TIMESTAMP_W;  // 73
    localparam int REC_NUM_LSB  = 0;
    localparam int REC_TYPE_LSB = REC_NUM_LSB + TRIG_NUM_W;   // 24
    localparam int REC_TS_LSB   = REC_TYPE_LSB + TRIG_TYPE_W; // 29

    // ----------------------------------------
    // acquisition event fifo
    // ----------------------------------------
    localparam int ACQ_FIFO_DEPTH = 16;                      // power of two, pointers wrap
    localparam int ACQ_FIFO_AFULL = 14;                      // almost-full threshold
    localparam int ACQ_FIFO_PTR_W = $clog2(ACQ_FIFO_DEPTH);
    localparam int ACQ_FIFO_CNT_W = ACQ_FIFO_PTR_W + 1;      // counts 0 .. DEPTH

    // acquisition controller fsm codes
    localparam int CAC_STATE_W = 3;
    localparam logic [CAC_STATE_W-1:0] CAC_IDLE  = 3'd0;  // waiting for an event
    localparam logic [CAC_STATE_W-1:0] CAC_DELAY = 3'd1;  // counting down trig_delay
    localparam logic [CAC_STATE_W-1:0] CAC_TRIG  = 3'd2;  // chan_trig out for one cycle
    localparam logic [CAC_STATE_W-1:0] CAC_WAIT  = 3'd3;  // waiting on chan_dones
    localparam logic [CAC_STATE_W-1:0] CAC_STORE = 3'd4;  // offering the record to the fifo

endpackage

//--- trig_event_if.sv
// one accepted ttc trigger passed from the trigger receiver (src) to the acquisition controller (dst)
interface trig_event_if;

    logic                             valid;      // one-cycle pulse per accepted trigger
    logic [trig_pkg::TRIG_NUM_W-1:0]  trig_num;   // starts at 1
    logic [trig_pkg::TRIG_TYPE_W-1:0] trig_type;
    logic [trig_pkg::TIMESTAMP_W-1:0] timestamp;  // counter value in the trigger cycle
    logic                             acq_ready;  // controller idle

    // receiver side
    modport src (
        output valid,
        output trig_num,
        output trig_type,
        output timestamp,
        input  acq_ready
    );

    // acquisition controller side
    modport dst (
        input  valid,
        input  trig_num,
        input  trig_type,
        input  timestamp,
        output acq_ready
    );

endinterface

//--- ttc_trigger_receiver.sv
// accepts ttc triggers when the acquisition controller is ready and hands them on numbered and timestamped
module ttc_trigger_receiver (
    input  logic ttc_clk,                  // 40 MHz
    input  logic rst_n,
    input  logic rst_trigger_num,          // ttc channel b
    input  logic rst_trigger_timestamp,    // ttc channel b
    input  logic ttc_trigger,
    input  logic [trig_pkg::TRIG_TYPE_W-1:0] trig_type,
    trig_event_if.src ev,
    output logic error_trig_rate           // sticky
);

    logic [trig_pkg::TIMESTAMP_W-1:0] ts_cnt;    // free-running timestamp
    logic [trig_pkg::TRIG_NUM_W-1:0]  trig_cnt;  // number of the last accepted trigger
    logic                             accept;
    logic                             drop;

    // the controller only drops acq_ready the cycle after valid,
    // so the cycle carrying valid is blocked here as well
    assign accept = ttc_trigger & ev.acq_ready & ~ev.valid;
    assign drop   = ttc_trigger & ~accept;   // trigger while busy

    // ----------------------------------------
    // counters
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            ts_cnt   <= '0;
            trig_cnt <= '0;
        end else begin
            if (rst_trigger_timestamp)
                ts_cnt <= '0;
            else
                ts_cnt <= ts_cnt + 1'b1;   // every cycle

            if (rst_trigger_num)
                trig_cnt <= '0;            // next trigger gets number 1
            else if (accept)
                trig_cnt <= trig_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // event out and rate error
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            ev.valid        <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            ev.valid <= accept;            // one cycle after the trigger
            if (drop)
                error_trig_rate <= 1'b1;   // held until reset
        end
    end

    // event fields, sampled in the trigger cycle
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            ev.trig_num  <= trig_cnt + 1'b1;
            ev.trig_type <= trig_type;
            ev.timestamp <= ts_cnt;
        end
    end

endmodule

//--- channel_acq_controller.sv
// delays each trigger, fires the enabled channels, waits for their dones and stores the event record
module channel_acq_controller (
    input  logic ttc_clk,
    input  logic rst_n,
    input  logic [trig_pkg::N_CHAN-1:0]  chan_en,      // channels that take part
    input  logic [trig_pkg::DELAY_W-1:0] trig_delay,   // extra cycles before chan_trig
    trig_event_if.dst ev,
    input  logic [trig_pkg::N_CHAN-1:0]  chan_dones,
    output logic [trig_pkg::N_CHAN-1:0]  chan_enable,
    output logic [trig_pkg::N_CHAN-1:0]  chan_trig,
    output logic rec_valid,                            // to the event fifo
    input  logic rec_ready,
    output logic [trig_pkg::ACQ_REC_W-1:0] rec_data
);

    logic [trig_pkg::CAC_STATE_W-1:0] state;
    logic [trig_pkg::DELAY_W-1:0]     delay_cnt;   // counts down to 1
    logic [trig_pkg::N_CHAN-1:0]      en_mask;     // chan_en at event time
    logic [trig_pkg::TRIG_NUM_W-1:0]  num_q;
    logic [trig_pkg::TRIG_TYPE_W-1:0] type_q;
    logic [trig_pkg::TIMESTAMP_W-1:0] ts_q;
    logic                             dones_ok;

    assign dones_ok = ((chan_dones & en_mask) == en_mask);   // all enabled channels done

    // ----------------------------------------
    // fsm
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            state     <= trig_pkg::CAC_IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                trig_pkg::CAC_IDLE: begin
                    if (ev.valid) begin
                        delay_cnt <= trig_delay;
                        // zero delay goes straight to the trigger cycle
                        state <= (trig_delay == '0) ? trig_pkg::CAC_TRIG : trig_pkg::CAC_DELAY;
                    end
                end
                trig_pkg::CAC_DELAY: begin
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt == trig_pkg::DELAY_W'(1))
                        state <= trig_pkg::CAC_TRIG;
                end
                trig_pkg::CAC_TRIG: begin
                    // nothing enabled, nothing to wait for
                    state <= (en_mask == '0) ? trig_pkg::CAC_STORE : trig_pkg::CAC_WAIT;
                end
                trig_pkg::CAC_WAIT: begin
                    if (dones_ok)
                        state <= trig_pkg::CAC_STORE;
                end
                trig_pkg::CAC_STORE: begin
                    if (rec_ready)
                        state <= trig_pkg::CAC_IDLE;   // record taken by the fifo
                end
                default: state <= trig_pkg::CAC_IDLE;
            endcase
        end
    end

    // event fields and channel mask, captured with the event
    always_ff @(posedge ttc_clk) begin
        if (state == trig_pkg::CAC_IDLE && ev.valid) begin
            en_mask <= chan_en;
            num_q   <= ev.trig_num;
            type_q  <= ev.trig_type;
            ts_q    <= ev.timestamp;
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign ev.acq_ready = (state == trig_pkg::CAC_IDLE);
    assign chan_trig    = (state == trig_pkg::CAC_TRIG) ? en_mask : '0;
    assign chan_enable  = (state == trig_pkg::CAC_DELAY ||
                           state == trig_pkg::CAC_TRIG  ||
                           state == trig_pkg::CAC_WAIT) ? en_mask : '0;
    assign rec_valid    = (state == trig_pkg::CAC_STORE);   // held until rec_ready

    // record packing, stable while rec_valid is up
    always_comb begin
        rec_data = '0;
        rec_data[trig_pkg::REC_NUM_LSB  +: trig_pkg::TRIG_NUM_W]  = num_q;
        rec_data[trig_pkg::REC_TYPE_LSB +: trig_pkg::TRIG_TYPE_W] = type_q;
        rec_data[trig_pkg::REC_TS_LSB   +: trig_pkg::TIMESTAMP_W] = ts_q;
    end

endmodule

//--- acq_event_fifo.sv
// first-word-fall-through fifo of event records between the acquisition controller and the trigger processor
module acq_event_fifo (
    input  logic ttc_clk,
    input  logic rst_n,
    input  logic in_valid,                               // write side
    output logic in_ready,
    input  logic [trig_pkg::ACQ_REC_W-1:0] in_data,
    output logic out_valid,                              // read side
    input  logic out_ready,
    output logic [trig_pkg::ACQ_REC_W-1:0] out_data,
    output logic almost_full
);

    logic [trig_pkg::ACQ_REC_W-1:0]      mem [trig_pkg::ACQ_FIFO_DEPTH];
    logic [trig_pkg::ACQ_FIFO_PTR_W-1:0] wr_ptr;
    logic [trig_pkg::ACQ_FIFO_PTR_W-1:0] rd_ptr;
    logic [trig_pkg::ACQ_FIFO_CNT_W-1:0] count;    // occupancy
    logic                                push;
    logic                                pop;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // ----------------------------------------
    // pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // none, or both at once
            endcase
        end
    end

    // storage
    always_ff @(posedge ttc_clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    // head word always on the output
    assign out_data    = mem[rd_ptr];
    assign out_valid   = (count != '0);
    assign in_ready    = ~count[trig_pkg::ACQ_FIFO_PTR_W];   // msb set only when full
    assign almost_full = (count >= trig_pkg::ACQ_FIFO_CNT_W'(trig_pkg::ACQ_FIFO_AFULL));

endmodule

//--- trigger_processor.sv
// pops event records and requests a readout from the command manager for each one
module trigger_processor (
    input  logic ttc_clk,
    input  logic rst_n,
    input  logic rec_valid,                           // from the event fifo
    output logic rec_ready,
    input  logic [trig_pkg::ACQ_REC_W-1:0] rec_data,
    input  logic readout_ready,                       // command manager idle
    input  logic readout_done,                        // one-cycle pulse
    output logic initiate_readout,
    output logic [trig_pkg::TRIG_NUM_W-1:0]  ttc_trig_num,
    output logic [trig_pkg::TRIG_TYPE_W-1:0] ttc_trig_type,
    output logic [trig_pkg::TIMESTAMP_W-1:0] ttc_trig_timestamp
);

    logic busy;   // 0 idle, 1 readout in progress
    logic pop;

    // pop only when idle and the command manager can take it
    assign rec_ready = ~busy & readout_ready;
    assign pop       = rec_valid & rec_ready;

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            busy             <= 1'b0;
            initiate_readout <= 1'b0;
        end else begin
            initiate_readout <= pop;       // one cycle, the cycle after the pop
            if (pop)
                busy <= 1'b1;
            else if (busy && readout_done)
                busy <= 1'b0;              // free to pop next cycle
        end
    end

    // unpack the record, values held until the next pop
    always_ff @(posedge ttc_clk) begin
        if (pop) begin
            ttc_trig_num       <= rec_data[trig_pkg::REC_NUM_LSB  +: trig_pkg::TRIG_NUM_W];
            ttc_trig_type      <= rec_data[trig_pkg::REC_TYPE_LSB +: trig_pkg::TRIG_TYPE_W];
            ttc_trig_timestamp <= rec_data[trig_pkg::REC_TS_LSB   +: trig_pkg::TIMESTAMP_W];
        end
    end

endmodule

//--- trigger_top.sv
// ttc-side trigger block top, connects receiver, acquisition controller, event fifo and trigger processor
module trigger_top (
    input  logic ttc_clk,                                    // 40 MHz
    input  logic rst_n,
    input  logic rst_trigger_num,                            // from ttc channel b
    input  logic rst_trigger_timestamp,                      // from ttc channel b
    input  logic ttc_trigger,
    input  logic [trig_pkg::TRIG_TYPE_W-1:0] trig_type,
    input  logic [trig_pkg::N_CHAN-1:0]      chan_en,
    input  logic [trig_pkg::DELAY_W-1:0]     trig_delay,
    input  logic [trig_pkg::N_CHAN-1:0]      chan_dones,
    output logic [trig_pkg::N_CHAN-1:0]      chan_enable,
    output logic [trig_pkg::N_CHAN-1:0]      chan_trig,
    input  logic readout_ready,                              // command manager idle
    input  logic readout_done,
    output logic initiate_readout,
    output logic [trig_pkg::TRIG_NUM_W-1:0]  ttc_trig_num,
    output logic [trig_pkg::TRIG_TYPE_W-1:0] ttc_trig_type,
    output logic [trig_pkg::TIMESTAMP_W-1:0] ttc_trig_timestamp,
    output logic acq_fifo_full,                              // almost full
    output logic error_trig_rate
);

    // ----------------------------------------
    // internal links
    // ----------------------------------------
    trig_event_if ev_if ();   // receiver to controller

    // controller to fifo
    logic                           s_acq_valid;
    logic                           s_acq_ready;
    logic [trig_pkg::ACQ_REC_W-1:0] s_acq_data;

    // fifo to processor
    logic                           m_acq_valid;
    logic                           m_acq_ready;
    logic [trig_pkg::ACQ_REC_W-1:0] m_acq_data;

    // ----------------------------------------
    // stages
    // ----------------------------------------
    ttc_trigger_receiver ttc_trigger_receiver (
        .ttc_clk(ttc_clk),
        .rst_n(rst_n),
        .rst_trigger_num(rst_trigger_num),
        .rst_trigger_timestamp(rst_trigger_timestamp),
        .ttc_trigger(ttc_trigger),
        .trig_type(trig_type),
        .ev(ev_if.src),
        .error_trig_rate(error_trig_rate)
    );

    channel_acq_controller channel_acq_controller (
        .ttc_clk(ttc_clk),
        .rst_n(rst_n),
        .chan_en(chan_en),
        .trig_delay(trig_delay),
        .ev(ev_if.dst),
        .chan_dones(chan_dones),
        .chan_enable(chan_enable),
        .chan_trig(chan_trig),
        .rec_valid(s_acq_valid),
        .rec_ready(s_acq_ready),
        .rec_data(s_acq_data)
    );

    acq_event_fifo acq_event_fifo (
        .ttc_clk(ttc_clk),
        .rst_n(rst_n),
        .in_valid(s_acq_valid),
        .in_ready(s_acq_ready),
        .in_data(s_acq_data),
        .out_valid(m_acq_valid),
        .out_ready(m_acq_ready),
        .out_data(m_acq_data),
        .almost_full(acq_fifo_full)
    );

    trigger_processor trigger_processor (
        .ttc_clk(ttc_clk),
        .rst_n(rst_n),
        .rec_valid(m_acq_valid),
        .rec_ready(m_acq_ready),
        .rec_data(m_acq_data),
        .readout_ready(readout_ready),
        .readout_done(readout_done),
        .initiate_readout(initiate_readout),
        .ttc_trig_num(ttc_trig_num),
        .ttc_trig_type(ttc_trig_type),
        .ttc_trig_timestamp(ttc_trig_timestamp)
    );

endmodule

//--- trigger_top_chk.sv
// concurrent checks on the acquisition controller outputs, bound into every channel_acq_controller
module trigger_top_chk (
    input logic ttc_clk,
    input logic rst_n,
    input logic [trig_pkg::N_CHAN-1:0]    chan_enable,
    input logic [trig_pkg::N_CHAN-1:0]    chan_trig,
    input logic                           rec_valid,
    input logic                           rec_ready,
    input logic [trig_pkg::ACQ_REC_W-1:0] rec_data
);

    int fail_count = 0;   // failure tally

    // chan_trig only on enabled channels
    a_trig_in_enable: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (chan_trig & ~chan_enable) == '0)
    else begin
        fail_count++;
        $error("chan_trig fired on a channel that is not enabled");
    end

    a_trig_one_cycle: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (chan_trig != '0) |=> (chan_trig == '0))   // single pulse per event
    else begin
        fail_count++;
        $error("chan_trig stayed high for more than one cycle");
    end

    // record offered to the fifo must not change until taken
    a_rec_hold: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (rec_valid && !rec_ready) |=> (rec_valid && $stable(rec_data)))
    else begin
        fail_count++;
        $error("rec_valid or rec_data changed before rec_ready");
    end

endmodule

bind channel_acq_controller trigger_top_chk chk (
    .ttc_clk(ttc_clk),
    .rst_n(rst_n),
    .chan_enable(chan_enable),
    .chan_trig(chan_trig),
    .rec_valid(rec_valid),
    .rec_ready(rec_ready),
    .rec_data(rec_data)
);

//--- tb_trigger_top.sv
// table-driven testbench for trigger_top, with channel and command-manager models and a scoreboard
module tb_trigger_top;

    localparam int N_ROWS      = 20;
    localparam int AFULL_LEVEL = 14;   // waiting records that raise acq_fifo_full

    logic ttc_clk;
    logic rst_n;
    logic rst_trigger_num;
    logic rst_trigger_timestamp;
    logic ttc_trigger;
    logic [trig_pkg::TRIG_TYPE_W-1:0] trig_type;
    logic [trig_pkg::N_CHAN-1:0]      chan_en;
    logic [trig_pkg::DELAY_W-1:0]     trig_delay;
    logic [trig_pkg::N_CHAN-1:0]      chan_dones;
    logic [trig_pkg::N_CHAN-1:0]      chan_enable;
    logic [trig_pkg::N_CHAN-1:0]      chan_trig;
    logic readout_ready;
    logic readout_done;
    logic initiate_readout;
    logic [trig_pkg::TRIG_NUM_W-1:0]  ttc_trig_num;
    logic [trig_pkg::TRIG_TYPE_W-1:0] ttc_trig_type;
    logic [trig_pkg::TIMESTAMP_W-1:0] ttc_trig_timestamp;
    logic acq_fifo_full;
    logic error_trig_rate;

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    logic [trig_pkg::TRIG_TYPE_W-1:0] t_type  [N_ROWS];
    logic [trig_pkg::N_CHAN-1:0]      t_mask  [N_ROWS];
    int                               t_delay [N_ROWS];
    int                               t_dones [N_ROWS];   // cycles until dones
    int                               t_wait  [N_ROWS];   // command manager busy time
    bit                               t_stall [N_ROWS];   // readout_ready held low

    // scoreboard, one entry per accepted trigger
    logic [trig_pkg::TRIG_NUM_W-1:0]  q_num  [$];
    logic [trig_pkg::TRIG_TYPE_W-1:0] q_type [$];
    longint                           q_cyc  [$];   // cycle the trigger was driven
    int                               q_wait [$];

    int     errors_val   = 0;
    int     errors_other = 0;
    int     exp_num      = 0;
    int     n_stalled    = 0;
    longint cyc          = 0;
    longint cyc_limit    = 400;   // margin for reset and the extra steps
    bit     stall        = 1'b0;
    bit     have_ts0     = 1'b0;
    logic [trig_pkg::TIMESTAMP_W-1:0] ts0;
    longint cyc0;

    trigger_top DUT (.*);

    initial begin
        ttc_clk = 1'b0;
        forever #4 ttc_clk = ~ttc_clk;
    end

    // cycle count and run limit
    always @(posedge ttc_clk) begin
        cyc <= cyc + 1;
        if (cyc > cyc_limit) begin
            $display("timeout: run did not finish within %0d cycles", cyc_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            errors_val++;
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic set_row(input int r, input int ty, input int m, input int d,
                           input int dn, input int w, input bit s);
        t_type[r]  = trig_pkg::TRIG_TYPE_W'(ty);
        t_mask[r]  = trig_pkg::N_CHAN'(m);
        t_delay[r] = d;
        t_dones[r] = dn;
        t_wait[r]  = w;
        t_stall[r] = s;
        cyc_limit  = cyc_limit + d + dn + w + 14;   // worst case per row
    endtask

    task automatic fill_table();
        //      row type mask  dly dones wait stall
        set_row(0,   1, 'h1f,  0,  3,   2,   0);
        set_row(1,   2, 'h05,  4,  1,   5,   0);
        set_row(2,   7, 'h00,  2,  2,   0,   0);   // no channel enabled
        set_row(3,   3, 'h12,  9,  6,   1,   0);
        for (int r = 4; r < N_ROWS - 1; r++)   // long stall, fifo fills
            set_row(r, $urandom % 32, $urandom % 32, $urandom % 8, 1 + $urandom % 4,
                    $urandom % 4, 1);
        set_row(N_ROWS - 1, 4, 'h1f, 1, 2, 1, 0);   // stall released
    endtask

    // ----------------------------------------
    // one trigger through the channel model
    // ----------------------------------------
    task automatic run_row(input int r, input bit drop);
        logic [trig_pkg::N_CHAN-1:0] m;
        int d;
        int j;
        m = t_mask[r];
        d = t_delay[r];
        @(posedge ttc_clk);
        stall       <= t_stall[r];
        chan_en     <= m;
        trig_delay  <= trig_pkg::DELAY_W'(d);
        trig_type   <= t_type[r];
        ttc_trigger <= 1'b1;
        exp_num = exp_num + 1;
        q_num.push_back(trig_pkg::TRIG_NUM_W'(exp_num));
        q_type.push_back(t_type[r]);
        q_cyc.push_back(cyc);
        q_wait.push_back(t_wait[r]);
        @(posedge ttc_clk);
        ttc_trigger <= 1'b0;
        @(negedge ttc_clk);   // valid cycle, controller still idle
        // valid one cycle after the trigger, chan_trig delay+1 cycles later
        for (j = 2; j <= d + 2; j++) begin
            @(negedge ttc_clk);
            check_val("chan_enable", chan_enable, m);
            check_val("chan_trig", chan_trig, (j == d + 2) ? m : '0);
        end
        if (drop) begin
            @(posedge ttc_clk);
            ttc_trigger <= 1'b1;   // controller still waiting on dones
            @(posedge ttc_clk);
            ttc_trigger <= 1'b0;
            @(negedge ttc_clk);
            check_val("error_trig_rate", error_trig_rate, 1);
        end
        repeat (t_dones[r]) begin
            @(negedge ttc_clk);
            check_val("chan_enable", chan_enable, m);
        end
        @(posedge ttc_clk);
        chan_dones <= m;
        @(negedge ttc_clk);
        while (!DUT.ev_if.acq_ready)   // record moved into the fifo
            @(negedge ttc_clk);
        if (t_stall[r]) begin
            n_stalled++;
            check_val("acq_fifo_full", acq_fifo_full, n_stalled >= AFULL_LEVEL);
        end else begin
            n_stalled = 0;
        end
        @(posedge ttc_clk);
        chan_dones <= '0;
    endtask

    // ----------------------------------------
    // command manager model and scoreboard
    // ----------------------------------------
    always @(posedge ttc_clk)
        readout_ready <= !stall;

    initial begin : cmd_model
        int w;
        longint c;
        readout_ready = 1'b0;
        readout_done  = 1'b0;
        forever begin
            @(negedge ttc_clk);
            if (initiate_readout === 1'b1) begin
                assert (q_num.size() != 0) else begin
                    errors_other++;
                    $display("readout started for trigger %0d with no trigger outstanding",
                             ttc_trig_num);
                end
                if (q_num.size() != 0) begin
                    check_val("ttc_trig_num", ttc_trig_num, q_num.pop_front());
                    check_val("ttc_trig_type", ttc_trig_type, q_type.pop_front());
                    c = q_cyc.pop_front();
                    w = q_wait.pop_front();
                    if (!have_ts0) begin
                        ts0      = ttc_trig_timestamp;   // reference event
                        cyc0     = c;
                        have_ts0 = 1'b1;
                    end else begin
                        check_val("ttc_trig_timestamp delta", ttc_trig_timestamp - ts0, c - cyc0);
                    end
                    repeat (w) @(posedge ttc_clk);
                    @(posedge ttc_clk);
                    readout_done <= 1'b1;
                    @(posedge ttc_clk);
                    readout_done <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        int chk_errors;
        void'($urandom(57319));
        fill_table();
        rst_n                 = 1'b0;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        chan_dones            = '0;
        repeat (5) @(posedge ttc_clk);
        rst_n <= 1'b1;
        @(negedge ttc_clk);
        check_val("acq_fifo_full", acq_fifo_full, 0);
        check_val("error_trig_rate", error_trig_rate, 0);
        check_val("chan_enable", chan_enable, 0);
        check_val("chan_trig", chan_trig, 0);
        check_val("initiate_readout", initiate_readout, 0);
        assert (DUT.ev_if.acq_ready === 1'b1) else begin
            errors_other++;
            $display("acq_ready is not high after reset");
        end

        for (int r = 0; r < N_ROWS; r++) begin
            if (t_stall[r] && n_stalled == 0)
                while (q_num.size() != 0)   // start the stall with an empty fifo
                    @(negedge ttc_clk);
            run_row(r, 1'b0);
        end
        check_val("error_trig_rate", error_trig_rate, 0);

        run_row(0, 1'b1);   // second trigger dropped while busy

        @(posedge ttc_clk);
        rst_trigger_num <= 1'b1;
        @(posedge ttc_clk);
        rst_trigger_num <= 1'b0;
        exp_num = 0;   // numbering restarts
        run_row(1, 1'b0);

        while (q_num.size() != 0)
            @(negedge ttc_clk);
        repeat (4) @(negedge ttc_clk);
        check_val("error_trig_rate", error_trig_rate, 1);   // sticky

        chk_errors = DUT.channel_acq_controller.chk.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 errors_val, errors_other, chk_errors);
        if (errors_val + errors_other + chk_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- trigger_top.f
trig_pkg.sv
trig_event_if.sv
ttc_trigger_receiver.sv
channel_acq_controller.sv
acq_event_fifo.sv
trigger_processor.sv
trigger_top.sv
trigger_top_chk.sv
tb_trigger_top.sv

//--- Bender.yml
package:
  name: trigger_top

sources:
  - trig_pkg.sv
  - trig_event_if.sv
  - ttc_trigger_receiver.sv
  - channel_acq_controller.sv
  - acq_event_fifo.sv
  - trigger_processor.sv
  - trigger_top.sv
  - target: simulation
    files:
      - trigger_top_chk.sv
      - tb_trigger_top.sv
